/* source/alloc_cfg.svh */
`ifndef ALLOC_CFG_SVH
`define ALLOC_CFG_SVH

// index width of the cell pool, 2**n cells of one word each
// 4 gives 16 cells, must stay below 8 so the pad field is not empty
`define ALLOC_ADDR_SZ 4

// tag byte in the upper half of every valid address
// first cell lands on 16'h5000
`define ALLOC_BASE 8'h50

// returned for a failed alloc and for data that is not a read
// also the value a freshly allocated cell is cleared to
`define ALLOC_UNDEF 16'h0000

`endif

/* source/alloc_types_pkg.sv */
`include "alloc_cfg.svh"

package alloc_types_pkg;

  // bits between the tag byte and the index
  localparam int PAD_SZ = 8 - `ALLOC_ADDR_SZ;

  typedef logic [`ALLOC_ADDR_SZ-1:0] cell_idx_t;  // one cell of the pool

  typedef logic [15:0] word_t;  // payload held by a cell

  // field view of an address word
  typedef struct packed {
    logic [7:0]        tag;  // must be ALLOC_BASE
    logic [PAD_SZ-1:0] pad;  // nonzero means index past the pool
    cell_idx_t         idx;
  } addr_fields_t;

  // same 16 bits seen two ways
  // raw on ports and compares, f when the core decodes
  typedef union packed {
    word_t        raw;
    addr_fields_t f;
  } addr_u;

endpackage

/* source/alloc_ops_pkg.sv */
package alloc_ops_pkg;

  import alloc_types_pkg::*;

  // one opcode per request kind
  typedef enum logic [1:0] {
    OP_ALLOC = 2'b00,  // grab lowest free cell
    OP_FREE  = 2'b01,  // give a cell back
    OP_WRITE = 2'b10,  // store into allocated cell
    OP_READ  = 2'b11   // load from allocated cell
  } op_e;

  // host command, 34 bits
  typedef struct packed {
    op_e   op;
    addr_u addr;  // ignored for alloc
    word_t data;  // only used by write
  } alloc_cmd_t;

  // result of one command, 35 bits
  typedef struct packed {
    op_e   op;    // echoed opcode
    addr_u addr;  // new cell on alloc, echo otherwise
    word_t data;  // read word, else undef
    logic  err;   // any fault
  } alloc_rsp_t;

endpackage

/* source/cmd_front.sv */
module cmd_front
  import alloc_ops_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_req,      // four-phase request from host
  input  alloc_cmd_t i_cmd,      // held while i_req is high
  input  logic       i_busy,     // response side still closing a cycle
  output logic       o_cmd_vld,  // one cycle per accepted request
  output alloc_cmd_t o_cmd
);

  logic taken;    // current request already passed on
  logic new_req;

  // fresh request, pipeline free, not seen before
  assign new_req = i_req && !i_busy && !taken;

  // control state
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_cmd_vld <= 1'b0;
      taken     <= 1'b0;
    end else begin
      o_cmd_vld <= new_req;  // single pulse
      if (new_req)
        taken <= 1'b1;
      else if (!i_req)
        taken <= 1'b0;       // host let go, ready for next
    end
  end

  // command payload, only loaded on capture
  always_ff @(posedge clk) begin
    if (new_req)
      o_cmd <= i_cmd;
  end

  // host must not touch the command until it drops req
  // otherwise o_rsp no longer matches what it sent
  a_cmd_stable : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_req && taken) |-> $stable(i_cmd)
  ) else $error("i_cmd changed while request held");

endmodule

/* source/alloc_core.sv */
`include "alloc_cfg.svh"

module alloc_core
  import alloc_types_pkg::*, alloc_ops_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_cmd_vld,  // one command this cycle
  input  alloc_cmd_t i_cmd,
  output logic       o_rsp_vld,  // follows i_cmd_vld by one cycle
  output alloc_rsp_t o_rsp
);

  localparam int CELLS = 1 << `ALLOC_ADDR_SZ;

  logic [CELLS-1:0] used;         // one bit per cell, set = allocated
  word_t            mem [CELLS];  // cell contents

  cell_idx_t  free_idx;    // lowest clear bit of used
  logic       free_hit;    // at least one free cell
  addr_u      cmd_addr;    // decode view of the incoming address
  addr_u      alloc_addr;  // address handed out by alloc
  logic       addr_ok;     // tag, pad and used bit all fine
  logic       fault;
  alloc_rsp_t rsp_nxt;

  // lowest free cell, scan from the top so index 0 wins
  always_comb begin
    free_idx = '0;
    free_hit = 1'b0;
    for (int i = CELLS - 1; i >= 0; i--) begin
      if (!used[i]) begin
        free_hit = 1'b1;
        free_idx = cell_idx_t'(i);
      end
    end
  end

  assign cmd_addr = i_cmd.addr;

  // free/write/read all need a live cell of this pool
  assign addr_ok = (cmd_addr.f.tag == `ALLOC_BASE)
                && (cmd_addr.f.pad == '0)       // index inside the pool
                && used[cmd_addr.f.idx];

  always_comb begin
    alloc_addr.raw   = '0;           // pad stays zero
    alloc_addr.f.tag = `ALLOC_BASE;
    alloc_addr.f.idx = free_idx;
  end

  always_comb begin
    case (i_cmd.op)
      OP_ALLOC: fault = !free_hit;   // pool full
      default:  fault = !addr_ok;
    endcase
  end

  // response word for this command
  always_comb begin
    rsp_nxt.op   = i_cmd.op;
    rsp_nxt.addr = i_cmd.addr;       // echo by default
    rsp_nxt.data = `ALLOC_UNDEF;
    rsp_nxt.err  = fault;
    case (i_cmd.op)
      OP_ALLOC: rsp_nxt.addr.raw = free_hit ? alloc_addr.raw : `ALLOC_UNDEF;
      OP_READ: begin
        if (!fault)
          rsp_nxt.data = mem[cmd_addr.f.idx];
      end
      default: ;
    endcase
  end

  // bitmap and handshake, faults leave the bitmap alone
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      used      <= '0;               // everything free
      o_rsp_vld <= 1'b0;
    end else begin
      o_rsp_vld <= i_cmd_vld;
      if (i_cmd_vld && !fault) begin
        case (i_cmd.op)
          OP_ALLOC: used[free_idx]       <= 1'b1;
          OP_FREE:  used[cmd_addr.f.idx] <= 1'b0;
          default: ;                     // write/read keep the map
        endcase
      end
    end
  end

  // cell storage
  always_ff @(posedge clk) begin
    if (i_cmd_vld && !fault) begin
      if (i_cmd.op == OP_ALLOC)
        mem[free_idx] <= `ALLOC_UNDEF;     // fresh cell reads back undef
      else if (i_cmd.op == OP_WRITE)
        mem[cmd_addr.f.idx] <= i_cmd.data;
    end
  end

  // registered result
  always_ff @(posedge clk) begin
    if (i_cmd_vld)
      o_rsp <= rsp_nxt;
  end

  // a good alloc adds exactly one cell to the map
  // a bit already set would leave the count flat
  a_alloc_new_bit : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_cmd_vld && i_cmd.op == OP_ALLOC && free_hit)
      |=> ($countones(used) == $past($countones(used)) + 1)
  ) else $error("alloc reused an allocated cell");

  // only one command in flight
  // a new command never lands on a response cycle
  a_one_in_flight : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_rsp_vld |-> !i_cmd_vld
  ) else $error("command overlaps a pending response");

endmodule

/* source/rsp_stage.sv */
module rsp_stage
  import alloc_ops_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_rsp_vld,  // result pulse from the core
  input  alloc_rsp_t i_rsp,
  input  logic       i_req,      // host request level
  output logic       o_busy,     // holds off new captures
  output logic       o_ack,
  output alloc_rsp_t o_rsp,      // valid while o_ack is high
  output logic       o_err,      // sticky until reset
  output logic       o_led_r,
  output logic       o_led_g,
  output logic       o_led_b
);

  // busy from the pulse itself until ack drops
  assign o_busy = i_rsp_vld || o_ack;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack   <= 1'b0;
      o_err   <= 1'b0;
      o_led_g <= 1'b0;
      o_led_b <= 1'b0;
    end else begin
      if (i_rsp_vld) begin
        o_ack   <= 1'b1;
        o_led_b <= (i_rsp.op == OP_FREE) && !i_rsp.err;  // clean free only
        if (i_rsp.err)
          o_err <= 1'b1;
        if (i_rsp.op == OP_ALLOC)
          o_led_g <= |i_rsp.addr.raw[7:0];               // low byte nonzero
      end else if (!i_req) begin
        o_ack   <= 1'b0;             // phase 4, host released
        o_led_b <= 1'b0;             // blue lasts one ack span
      end
    end
  end

  // held for the host until the next result
  always_ff @(posedge clk) begin
    if (i_rsp_vld)
      o_rsp <= i_rsp;
  end

  assign o_led_r = o_err;  // red mirrors sticky error

  // ack only answers a live request
  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    $rose(o_ack) |-> i_req
  ) else $error("ack raised with no request");

endmodule

/* source/alloc_top.sv */
module alloc_top
  import alloc_ops_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_req,    // four-phase request
  input  alloc_cmd_t i_cmd,
  output logic       o_ack,
  output alloc_rsp_t o_rsp,
  output logic       o_err,    // sticky error
  output logic       o_led_r,
  output logic       o_led_g,
  output logic       o_led_b
);

  logic       cmd_vld;
  alloc_cmd_t cmd;
  logic       rsp_vld;
  alloc_rsp_t rsp;
  logic       rsp_busy;  // back from stage 3 to stage 1

  // stage 1, request capture
  cmd_front u_front (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_req     (i_req),
    .i_cmd     (i_cmd),
    .i_busy    (rsp_busy),
    .o_cmd_vld (cmd_vld),
    .o_cmd     (cmd)
  );

  // stage 2, bitmap and cells
  alloc_core u_core (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_cmd_vld (cmd_vld),
    .i_cmd     (cmd),
    .o_rsp_vld (rsp_vld),
    .o_rsp     (rsp)
  );

  // stage 3, ack and indicators
  rsp_stage u_rsp (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_rsp_vld (rsp_vld),
    .i_rsp     (rsp),
    .i_req     (i_req),
    .o_busy    (rsp_busy),
    .o_ack     (o_ack),
    .o_rsp     (o_rsp),
    .o_err     (o_err),
    .o_led_r   (o_led_r),
    .o_led_g   (o_led_g),
    .o_led_b   (o_led_b)
  );

endmodule

/* test/tb_alloc_top.sv */
`include "alloc_cfg.svh"

module tb_alloc_top
  import alloc_types_pkg::*, alloc_ops_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CELLS   = 1 << `ALLOC_ADDR_SZ;
  localparam int TIMEOUT = 50;  // cycles per handshake phase
  localparam int ACK_LAT = 3;   // drive edge to ack edge
  localparam int REL_LAT = 1;   // release drive edge to ack drop

  // one command and what must come back
  typedef struct packed {
    op_e        op;
    word_t      addr;
    word_t      data;
    word_t      exp_addr;
    word_t      exp_data;
    logic       exp_err;
    logic [3:0] hold;      // extra cycles with req held after ack
  } row_t;

  logic       clk;
  logic       i_arst_n;
  logic       i_req;
  alloc_cmd_t i_cmd;
  logic       o_ack, o_err, o_led_r, o_led_g, o_led_b;
  alloc_rsp_t o_rsp;

  row_t  table_q[$];
  logic  err_seen;   // sticky error model
  logic  led_g_exp;  // low byte OR of the last alloc
  word_t rnd0, rnd1;

  alloc_top u_dut (.*);

  always #2 clk = ~clk;  // 4 ns period

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // sample at negedge, away from the drive edge
  task automatic wait_ack(input logic level, output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles <= TIMEOUT) begin
      @(negedge clk);
      if (o_ack === level)
        seen = 1'b1;
      else
        cycles++;
    end
    if (!seen) begin
      $display("timeout: o_ack did not go to %0b within %0d cycles", level, TIMEOUT);
      $display("TEST FAILED");
      $fatal(1, "handshake timeout");
    end
  endtask

  task automatic add_row(input op_e op, input word_t addr, input word_t data,
                         input word_t exp_addr, input word_t exp_data,
                         input logic exp_err, input int hold);
    row_t r;
    r = '{op, addr, data, exp_addr, exp_data, exp_err, 4'(hold)};
    table_q.push_back(r);
  endtask

  // one full four-phase cycle plus all checks
  task automatic run_row(input row_t r);
    int lat;
    int fall;
    @(posedge clk);
    i_cmd.op       <= r.op;
    i_cmd.addr.raw <= r.addr;
    i_cmd.data     <= r.data;
    i_req          <= 1'b1;
    wait_ack(1'b1, lat);
    check_val("ack latency", 16'(lat), 16'(ACK_LAT));
    check_val("o_rsp.op", 16'(o_rsp.op), 16'(r.op));
    check_val("o_rsp.addr", o_rsp.addr.raw, r.exp_addr);
    check_val("o_rsp.data", o_rsp.data, r.exp_data);
    check_val("o_rsp.err", 16'(o_rsp.err), 16'(r.exp_err));
    err_seen = err_seen | r.exp_err;
    if (r.op == OP_ALLOC)
      led_g_exp = |r.exp_addr[7:0];
    check_val("o_err", 16'(o_err), 16'(err_seen));
    check_val("o_led_r", 16'(o_led_r), 16'(err_seen));
    check_val("o_led_g", 16'(o_led_g), 16'(led_g_exp));
    check_val("o_led_b", 16'(o_led_b), 16'((r.op == OP_FREE) && !r.exp_err));
    repeat (int'(r.hold)) begin
      @(negedge clk);
      check_val("o_ack held", 16'(o_ack), 16'd1);  // back-pressure keeps ack up
    end
    @(posedge clk);
    i_req <= 1'b0;
    wait_ack(1'b0, fall);
    check_val("ack release latency", 16'(fall), 16'(REL_LAT));  // first low sample drops it
  endtask

  initial begin
    void'($urandom(32'hf49a));  // single seed for the run
    rnd0      = word_t'($urandom());
    rnd1      = word_t'($urandom());
    clk       = 1'b0;
    i_arst_n  = 1'b0;
    i_req     = 1'b0;
    i_cmd     = '0;
    err_seen  = 1'b0;
    led_g_exp = 1'b0;

    add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5000, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5001, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5002, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_WRITE, 16'h5001, rnd0,     16'h5001, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_READ,  16'h5001, 16'h0000, 16'h5001, rnd0,         1'b0, 0);
    add_row(OP_WRITE, 16'h5000, rnd1,     16'h5000, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_FREE,  16'h5001, 16'h0000, 16'h5001, `ALLOC_UNDEF, 1'b0, 0);  // blue on
    add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5001, `ALLOC_UNDEF, 1'b0, 5);  // held req
    add_row(OP_READ,  16'h5001, 16'h0000, 16'h5001, `ALLOC_UNDEF, 1'b0, 0);  // cleared
    add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5003, `ALLOC_UNDEF, 1'b0, 0);  // one taken
    add_row(OP_FREE,  16'h4001, 16'h0000, 16'h4001, `ALLOC_UNDEF, 1'b1, 0);  // bad tag
    add_row(OP_FREE,  16'h5010, 16'h0000, 16'h5010, `ALLOC_UNDEF, 1'b1, 0);  // past pool
    add_row(OP_FREE,  16'h5003, 16'h0000, 16'h5003, `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_FREE,  16'h5003, 16'h0000, 16'h5003, `ALLOC_UNDEF, 1'b1, 0);  // double free
    add_row(OP_READ,  16'h5003, 16'h0000, 16'h5003, `ALLOC_UNDEF, 1'b1, 0);  // free cell
    add_row(OP_READ,  16'h5000, 16'h0000, 16'h5000, rnd1,         1'b0, 0);  // state intact
    for (int i = 3; i < CELLS; i++)
      add_row(OP_ALLOC, 16'h0000, 16'h0000, 16'h5000 + 16'(i), `ALLOC_UNDEF, 1'b0, 0);
    add_row(OP_ALLOC, 16'h0000, 16'h0000, `ALLOC_UNDEF, `ALLOC_UNDEF, 1'b1, 0);  // pool full

    repeat (5) @(posedge clk);
    i_arst_n <= 1'b1;
    @(negedge clk);
    check_val("o_ack", 16'(o_ack), 16'd0);  // idle after reset
    check_val("o_err", 16'(o_err), 16'd0);
    check_val("o_led_r", 16'(o_led_r), 16'd0);
    check_val("o_led_g", 16'(o_led_g), 16'd0);
    check_val("o_led_b", 16'(o_led_b), 16'd0);

    foreach (table_q[i])
      run_row(table_q[i]);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/alloc_types_pkg.sv
source/alloc_ops_pkg.sv
source/cmd_front.sv
source/alloc_core.sv
source/rsp_stage.sv
source/alloc_top.sv
test/tb_alloc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the allocator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module tb_alloc_top; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vtb_alloc_top 2>&1); then
  echo "$out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
